// ==== exPkg.sv ====
// Shared widths, op codes and stage bundles for the two execute stages
package exPkg;

	typedef logic [63:0] word64;	// Data word
	typedef logic [64:0] aluWide;	// ALU value plus flag bit
	typedef logic [5:0]  regId;		// GPR number
	typedef logic [7:0]  uCmd;		// Pred code in 7:6, operation in 5:0
	typedef logic [7:0]  uIxt;		// ALU function, or multiply mode in 1:0
	typedef logic [15:0] memAddr;	// Byte address
	typedef logic [32:0] immVal;	// Decoded displacement

	// Operations, low six bits of uCmd
	localparam logic [5:0] opNop    = 6'h00;
	localparam logic [5:0] opMovRm  = 6'h01;	// Store Rm to memory
	localparam logic [5:0] opMovMr  = 6'h02;	// Load memory to Rm
	localparam logic [5:0] opAlu3   = 6'h03;
	localparam logic [5:0] opAluCmp = 6'h04;
	localparam logic [5:0] opMul3   = 6'h05;

	// Predication, high two bits of uCmd
	localparam logic [1:0] predAlways  = 2'b00;
	localparam logic [1:0] predNever   = 2'b01;
	localparam logic [1:0] predIfTrue  = 2'b10;
	localparam logic [1:0] predIfFalse = 2'b11;

	localparam uIxt aluAdd   = 8'h00;	// Carry in flag bit
	localparam uIxt aluSub   = 8'h01;	// Borrow in flag bit
	localparam uIxt aluAnd   = 8'h02;
	localparam uIxt aluOr    = 8'h03;
	localparam uIxt aluXor   = 8'h04;
	localparam uIxt aluCmpEq = 8'h05;
	localparam uIxt aluCmpGt = 8'h06;	// Signed compare

	typedef enum logic [1:0] {
		mulSignedLow    = 2'b00,	// Rm gets sign-extended low half
		mulUnsignedLow  = 2'b01,	// Rm gets zero-extended low half
		mulSignedWide   = 2'b10,	// DLR/DHR, DHR sign-extended
		mulUnsignedWide = 2'b11		// DLR/DHR, DHR zero-extended
	} mulMode;

	typedef enum logic [1:0] {
		memIdle = 2'b00,
		memOk   = 2'b01,	// Access done, data valid
		memHold = 2'b10		// Bit 1 set means hold
	} memStatus;

	localparam int memWaitCycles = 3;	// Hold cycles per access
	localparam int memDepthWords = 256;
	localparam int memIndexBits  = $clog2(memDepthWords);

	typedef struct packed {
		uCmd   cmd;
		uIxt   ixt;
		regId  idRs;	// Source A, ALU or base
		regId  idRt;	// Source B
		regId  idRm;	// Store source or destination
		word64 valRs;
		word64 valRt;
		word64 valRm;
		immVal imm;
	} microOp;

	typedef struct packed {
		logic   enable;
		logic   write;
		memAddr addr;
		word64  wdata;
	} memReq;

	typedef struct packed {
		logic  valid;
		regId  id;
		word64 value;
	} wbPort;

	// Stage 1 to stage 2 pipeline register
	typedef struct packed {
		microOp op;		// Op with predication already resolved
		aluWide aluRes;
	} ex1Bus;

endpackage

// ==== exAlu.sv ====
`timescale 1ns/1ps
// Combinational 64-bit ALU, flag outcome returned in bit 64 of the result
module exAlu (
	input  exPkg::word64  a,
	input  exPkg::word64  b,
	input  exPkg::uIxt    func,
	output exPkg::aluWide result
);
	import exPkg::*;

	logic isEq;		// Operands equal
	logic isGt;		// a above b, signed

	assign isEq = (a == b);
	assign isGt = ($signed(a) > $signed(b));

	always_comb begin
		result = '0;
		case (func)
			aluAdd: begin
				result = {1'b0, a} + {1'b0, b};	// Carry lands in bit 64
			end
			aluSub: begin
				result = {1'b0, a} - {1'b0, b};	// Borrow lands in bit 64
			end
			aluAnd: begin
				result = {1'b0, a & b};
			end
			aluOr: begin
				result = {1'b0, a | b};
			end
			aluXor: begin
				result = {1'b0, a ^ b};
			end
			aluCmpEq: begin
				result = {isEq, 63'b0, isEq};	// Outcome also as value
			end
			aluCmpGt: begin
				result = {isGt, 63'b0, isGt};
			end
			default: begin
				result = {1'b0, a};	// Unknown func passes A
			end
		endcase
	end

endmodule

// ==== exMultiplier.sv ====
`timescale 1ns/1ps
// Two-cycle pipelined 32x32 multiplier with signed or unsigned operands
module exMultiplier (
	input  logic          clock,
	input  logic          rst,
	input  logic          hold,
	input  logic          start,
	input  logic [31:0]   a,
	input  logic [31:0]   b,
	input  exPkg::mulMode mode,
	output logic [63:0]   product
);
	import exPkg::*;

	logic               isSigned;	// Mode wants two's complement
	logic signed [32:0] aReg;		// Operand with extension bit
	logic signed [32:0] bReg;
	logic signed [65:0] fullProd;	// 33x33 product

	assign isSigned = (mode == mulSignedLow) || (mode == mulSignedWide);

	// First stage, operands captured with their signedness
	always_ff @(posedge clock) begin
		if (rst) begin
			aReg <= '0;
			bReg <= '0;
		end else if (start && !hold) begin
			aReg <= {isSigned & a[31], a};
			bReg <= {isSigned & b[31], b};
		end
	end

	assign fullProd = aReg * bReg;	// Zero top bit keeps unsigned exact

	// Second stage
	always_ff @(posedge clock) begin
		if (rst) begin
			product <= '0;
		end else if (!hold) begin
			product <= fullProd[63:0];	// Only 64 bits are meaningful
		end
	end

endmodule

// ==== dataMemory.sv ====
`timescale 1ns/1ps
// L1-like data memory with a fixed wait, request frozen while reporting hold
module dataMemory (
	input  logic             clock,
	input  logic             rst,
	input  exPkg::memReq     req,
	output exPkg::word64     rdata,
	output exPkg::memStatus  status
);
	import exPkg::*;

	word64                   mem [memDepthWords];	// Word array
	memReq                   curReq;				// Captured request
	logic [3:0]              waitCnt;				// Hold cycles left minus one
	logic [memIndexBits-1:0] curIndex;				// Word index of captured addr
	logic                    accept;				// New request taken this edge
	logic                    finish;				// Last hold cycle

	assign curIndex = curReq.addr[3 +: memIndexBits];	// Byte to word
	assign accept   = req.enable && (status != memHold);
	assign finish   = (status == memHold) && (waitCnt == 4'd0);

	// Request register, left alone during hold
	always_ff @(posedge clock) begin
		if (accept) begin
			curReq <= req;
		end
	end

	// Status sequencing and array update
	always_ff @(posedge clock) begin
		if (rst) begin
			status  <= memIdle;
			waitCnt <= '0;
			for (int i = 0; i < memDepthWords; i++) begin
				mem[i] <= '0;	// Untouched words read as zero
			end
		end else if (status == memHold) begin
			if (finish) begin
				status <= memOk;
				if (curReq.write) begin
					mem[curIndex] <= curReq.wdata;	// Store commits with memOk
				end
			end else begin
				waitCnt <= waitCnt - 4'd1;
			end
		end else if (accept) begin
			status  <= memHold;
			waitCnt <= 4'(memWaitCycles - 1);
		end else begin
			status <= memIdle;	// memOk lasts a single cycle
		end
	end

	// Read data, valid in the memOk cycle
	always_ff @(posedge clock) begin
		if (finish) begin
			rdata <= mem[curIndex];
		end
	end

endmodule

// ==== sprFile.sv ====
`timescale 1ns/1ps
// Special registers SR.T, DLR and DHR, written from stage 2 outside a hold
module sprFile (
	input  logic         clock,
	input  logic         rst,
	input  logic         hold,
	input  logic         setT,
	input  logic         newT,
	input  logic         setDlr,
	input  exPkg::word64 newDlr,
	input  logic         setDhr,
	input  exPkg::word64 newDhr,
	output logic         srT,
	output exPkg::word64 dlr,
	output exPkg::word64 dhr
);
	import exPkg::*;

	always_ff @(posedge clock) begin
		if (rst) begin
			srT <= 1'b0;
			dlr <= '0;
			dhr <= '0;
		end else if (!hold) begin
			if (setT) begin
				srT <= newT;	// Predication flag
			end
			if (setDlr) begin
				dlr <= newDlr;
			end
			if (setDhr) begin
				dhr <= newDhr;	// High half of wide multiply
			end
		end
	end

endmodule

// ==== exStage1.sv ====
`timescale 1ns/1ps
// Execute stage 1: op latch, predication, ALU operands, multiply start and memory issue
module exStage1 (
	input  logic            clock,
	input  logic            rst,
	input  logic            hold,
	input  exPkg::microOp   inOp,
	input  logic            opValid,
	input  logic            srT,
	input  exPkg::aluWide   aluResult,
	output exPkg::word64    aluA,
	output exPkg::word64    aluB,
	output exPkg::uIxt      aluFunc,
	output logic            mulStart,
	output logic [31:0]     mulA,
	output logic [31:0]     mulB,
	output exPkg::mulMode   mulSel,
	output exPkg::memReq    memRequest,
	output exPkg::ex1Bus    ex1Out
);
	import exPkg::*;

	microOp     opReg;		// Latched micro-op
	logic       opLive;		// Latched op arrived with opValid
	logic       liveT;		// T flag including the op now in stage 2
	logic       opEnable;	// Predicate outcome
	logic [5:0] effOp;		// Operation after predication
	logic       isMem;		// Load or store
	word64      immExt;		// Displacement widened to 64 bits

	always_ff @(posedge clock) begin
		if (rst) begin
			opLive <= 1'b0;
		end else if (!hold) begin
			opLive <= opValid;
		end
	end

	always_ff @(posedge clock) begin
		if (!hold) begin
			opReg <= inOp;
		end
	end

	// A flag op in stage 2 writes SR at this edge, so take its value directly
	always_comb begin
		liveT = srT;
		if (ex1Out.op.cmd[5:0] == opAlu3 || ex1Out.op.cmd[5:0] == opAluCmp) begin
			liveT = ex1Out.aluRes[64];
		end
	end

	always_comb begin
		case (opReg.cmd[7:6])
			predAlways:  opEnable = 1'b1;
			predNever:   opEnable = 1'b0;
			predIfTrue:  opEnable = liveT;
			predIfFalse: opEnable = !liveT;
			default:     opEnable = 1'b0;
		endcase
	end

	assign effOp  = (opLive && opEnable) ? opReg.cmd[5:0] : opNop;
	assign isMem  = (effOp == opMovRm) || (effOp == opMovMr);
	assign immExt = {{31{opReg.imm[32]}}, opReg.imm};	// Sign-extend

	// ALU doubles as the address adder for memory ops
	always_comb begin
		aluA    = opReg.valRs;
		aluB    = opReg.valRt;
		aluFunc = opReg.ixt;
		if (isMem) begin
			aluB    = immExt;	// Base plus displacement
			aluFunc = aluAdd;
		end
	end

	assign mulStart = (effOp == opMul3);
	assign mulA     = opReg.valRs[31:0];
	assign mulB     = opReg.valRt[31:0];
	assign mulSel   = mulMode'(opReg.ixt[1:0]);

	// Presented only on the edge the op moves on, so memory sees it once
	assign memRequest.enable = isMem && !hold;
	assign memRequest.write  = (effOp == opMovRm);
	assign memRequest.addr   = aluResult[15:0];
	assign memRequest.wdata  = opReg.valRm;	// Store data from Rm

	always_ff @(posedge clock) begin
		if (rst) begin
			ex1Out.op.cmd <= {predAlways, opNop};
		end else if (!hold) begin
			ex1Out.op     <= opReg;
			ex1Out.op.cmd <= {predAlways, effOp};	// Disabled ops arrive as NOP
			ex1Out.aluRes <= aluResult;
		end
	end

endmodule

// ==== exStage2.sv ====
`timescale 1ns/1ps
// Execute stage 2: result select, T and DLR/DHR update, hold on multiply and memory
module exStage2 (
	input  logic             clock,
	input  logic             rst,
	input  exPkg::ex1Bus     ex1In,
	input  logic [63:0]      mulProduct,
	input  exPkg::word64     memData,
	input  exPkg::memStatus  memState,
	output logic             exHold,
	output exPkg::wbPort     gprWb,
	output logic             setT,
	output logic             newT,
	output logic             setDlr,
	output exPkg::word64     newDlr,
	output logic             setDhr,
	output exPkg::word64     newDhr
);
	import exPkg::*;

	logic [3:0] holdCyc;	// Cycles held so far on this op
	logic [5:0] op;
	mulMode     mode;
	logic       memOp;		// Waits on the data memory
	logic       wbWant;		// Op writes a GPR
	logic       tWant;
	logic       dlrWant;
	logic       dhrWant;
	word64      wbValue;

	assign op   = ex1In.op.cmd[5:0];
	assign mode = mulMode'(ex1In.op.ixt[1:0]);

	always_comb begin
		exHold  = 1'b0;
		memOp   = 1'b0;
		wbWant  = 1'b0;
		tWant   = 1'b0;
		dlrWant = 1'b0;
		dhrWant = 1'b0;
		wbValue = ex1In.aluRes[63:0];	// ALU value by default
		newT    = ex1In.aluRes[64];
		newDlr  = {32'b0, mulProduct[31:0]};
		newDhr  = {{32{mulProduct[63]}}, mulProduct[63:32]};

		case (op)
			opMovRm: begin
				memOp = 1'b1;
			end
			opMovMr: begin
				memOp   = 1'b1;
				wbWant  = 1'b1;
				wbValue = memData;
			end
			opAlu3: begin
				wbWant = 1'b1;
				tWant  = 1'b1;	// Carry or outcome into T
			end
			opAluCmp: begin
				tWant = 1'b1;
			end
			opMul3: begin
				if (holdCyc != 4'd1) begin
					exHold = 1'b1;	// Product lands one cycle later
				end
				case (mode)
					mulSignedLow: begin
						wbWant  = 1'b1;
						wbValue = {{32{mulProduct[31]}}, mulProduct[31:0]};
					end
					mulUnsignedLow: begin
						wbWant  = 1'b1;
						wbValue = {32'b0, mulProduct[31:0]};
					end
					mulSignedWide: begin
						dlrWant = 1'b1;
						dhrWant = 1'b1;
					end
					default: begin
						dlrWant = 1'b1;
						dhrWant = 1'b1;
						newDhr  = {32'b0, mulProduct[63:32]};	// Zero-extended high
					end
				endcase
			end
			default: begin
			end
		endcase

		// First cycle always waits, then until memory leaves hold
		if (memOp && (holdCyc == 4'd0 || memState == memHold)) begin
			exHold = 1'b1;
		end

		gprWb.valid = wbWant && !exHold;	// Only on the last cycle
		gprWb.id    = ex1In.op.idRm;
		gprWb.value = wbValue;
		setT        = tWant && !exHold;
		setDlr      = dlrWant && !exHold;
		setDhr      = dhrWant && !exHold;
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			holdCyc <= '0;
		end else if (exHold) begin
			holdCyc <= holdCyc + 4'd1;
		end else begin
			holdCyc <= '0;	// Cleared as the op leaves
		end
	end

endmodule

// ==== exCore.sv ====
`timescale 1ns/1ps
// Execute core top, two stages with ALU, multiplier, data memory and special registers
module exCore (
	input  logic          clock,
	input  logic          rst,
	input  exPkg::microOp inOp,
	input  logic          opValid,
	output logic          exHold,
	output exPkg::wbPort  gprWb,
	output logic          srT,
	output exPkg::word64  dlr,
	output exPkg::word64  dhr
);
	import exPkg::*;

	word64       aluA;
	word64       aluB;
	uIxt         aluFunc;
	aluWide      aluResult;
	logic        mulStart;
	logic [31:0] mulA;
	logic [31:0] mulB;
	mulMode      mulSel;
	logic [63:0] mulProduct;
	logic        mulFreeze;		// Multiplier freeze
	memReq       memRequest;
	word64       memData;
	memStatus    memState;
	ex1Bus       ex1Data;		// Stage 1 to stage 2 register
	logic        setT;
	logic        newT;
	logic        setDlr;
	word64       newDlr;
	logic        setDhr;
	word64       newDhr;

	// Multiplier keeps running while stage 2 waits on its own product
	assign mulFreeze = exHold && (ex1Data.op.cmd[5:0] != opMul3);

	exStage1 stage1 (
		.clock(clock), .rst(rst), .hold(exHold), .inOp(inOp), .opValid(opValid),
		.srT(srT), .aluResult(aluResult), .aluA(aluA), .aluB(aluB),
		.aluFunc(aluFunc), .mulStart(mulStart), .mulA(mulA), .mulB(mulB),
		.mulSel(mulSel), .memRequest(memRequest), .ex1Out(ex1Data)
	);

	exAlu alu (.a(aluA), .b(aluB), .func(aluFunc), .result(aluResult));

	exMultiplier mul (
		.clock(clock), .rst(rst), .hold(mulFreeze), .start(mulStart),
		.a(mulA), .b(mulB), .mode(mulSel), .product(mulProduct)
	);

	dataMemory dmem (
		.clock(clock), .rst(rst), .req(memRequest), .rdata(memData), .status(memState)
	);

	exStage2 stage2 (
		.clock(clock), .rst(rst), .ex1In(ex1Data), .mulProduct(mulProduct),
		.memData(memData), .memState(memState), .exHold(exHold), .gprWb(gprWb),
		.setT(setT), .newT(newT), .setDlr(setDlr), .newDlr(newDlr),
		.setDhr(setDhr), .newDhr(newDhr)
	);

	sprFile spr (
		.clock(clock), .rst(rst), .hold(exHold), .setT(setT), .newT(newT),
		.setDlr(setDlr), .newDlr(newDlr), .setDhr(setDhr), .newDhr(newDhr),
		.srT(srT), .dlr(dlr), .dhr(dhr)
	);

endmodule

// ==== exCoreTb.sv ====
// Testbench for the execute core, directed and random micro-ops checked against a reference model
`timescale 1ns/1ps
module exCoreTb;
	import exPkg::*;

	localparam int clockPeriod    = 100;	// ns
	localparam int aluReps        = 4;		// Ops per ALU function
	localparam int mulReps        = 3;		// Ops per multiply mode
	localparam int burstLen       = 40;
	localparam int numOps         = 7 * aluReps + 10 + 4 * mulReps + 7 + burstLen;
	localparam int watchdogCycles = numOps * 10 + 200;	// Ten per op plus margin
	localparam int drainLimit     = 50;		// Cycles allowed to go idle

	logic   clock;
	logic   rst;
	microOp inOp;
	logic   opValid;
	logic   exHold;
	wbPort  gprWb;
	logic   srT;
	word64  dlr;
	word64  dhr;

	// Reference state, advanced in program order as ops are accepted
	logic   modelT;
	word64  modelDlr;
	word64  modelDhr;
	word64  memModel [memDepthWords];
	wbPort  expQ [$];		// Pending write-backs, oldest first
	int     holdOps;		// Enabled memory and multiply ops
	int     holdRises;		// exHold low to high
	logic   prevHold;
	int     checks;
	int     errors;
	int     tests;
	int     testChecks;		// Counts at test start
	int     testErrors;
	uIxt    aluFuncs [7] = '{aluAdd, aluSub, aluAnd, aluOr, aluXor, aluCmpEq, aluCmpGt};

	exCore u_dut (
		.clock(clock), .rst(rst), .inOp(inOp), .opValid(opValid), .exHold(exHold),
		.gprWb(gprWb), .srT(srT), .dlr(dlr), .dhr(dhr)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#(clockPeriod / 2) clock = ~clock;
		end
	end

	function automatic word64 randWord();
		return {$urandom(), $urandom()};
	endfunction

	function automatic microOp makeOp(input logic [1:0] pred, input logic [5:0] code,
		input uIxt ixt, input regId rm, input word64 rs, input word64 rt, input word64 rmVal,
		input immVal imm);
		microOp op;
		op       = '0;
		op.cmd   = {pred, code};
		op.ixt   = ixt;
		op.idRs  = 6'd1;
		op.idRt  = 6'd2;
		op.idRm  = rm;
		op.valRs = rs;
		op.valRt = rt;
		op.valRm = rmVal;	// Store data
		op.imm   = imm;
		return op;
	endfunction

	// Expected ALU value with the flag in bit 64
	function automatic aluWide aluRef(input uIxt func, input word64 a, input word64 b);
		aluWide r;
		logic   eq;
		logic   gt;
		eq = (a == b);
		gt = ($signed(a) > $signed(b));	// Signed compare
		r  = '0;
		case (func)
			aluAdd:   r = {1'b0, a} + {1'b0, b};	// Carry out on top
			aluSub:   r = {(a < b), a - b};			// Borrow when a below b
			aluAnd:   r[63:0] = a & b;
			aluOr:    r[63:0] = a | b;
			aluXor:   r[63:0] = a ^ b;
			aluCmpEq: r = {eq, 63'b0, eq};
			aluCmpGt: r = {gt, 63'b0, gt};
			default:  r[63:0] = a;
		endcase
		return r;
	endfunction

	function automatic word64 mulRef(input logic [31:0] a, input logic [31:0] b, input logic sgn);
		longint sa;
		longint sb;
		if (sgn) begin
			sa = longint'($signed(a));
			sb = longint'($signed(b));
		end else begin
			sa = longint'({32'b0, a});
			sb = longint'({32'b0, b});
		end
		return 64'(sa * sb);	// Wraps to the 64-bit pattern
	endfunction

	// Applies one accepted op to the reference state
	function automatic void predictOp(input microOp op);
		logic                    enable;
		mulMode                  mode;
		aluWide                  alu;
		word64                   prod;
		word64                   eff;
		logic [memIndexBits-1:0] idx;
		wbPort                   wb;
		case (op.cmd[7:6])
			predAlways: enable = 1'b1;
			predNever:  enable = 1'b0;
			predIfTrue: enable = modelT;
			default:    enable = !modelT;
		endcase
		mode     = mulMode'(op.ixt[1:0]);
		alu      = aluRef(op.ixt, op.valRs, op.valRt);
		prod     = mulRef(op.valRs[31:0], op.valRt[31:0],
			(mode == mulSignedLow) || (mode == mulSignedWide));
		eff      = op.valRs + {{31{op.imm[32]}}, op.imm};	// Base plus displacement
		idx      = eff[3 +: memIndexBits];					// 8-byte words
		wb.valid = 1'b1;
		wb.id    = op.idRm;
		wb.value = alu[63:0];
		if (enable) begin
			case (op.cmd[5:0])
				opAlu3: begin
					expQ.push_back(wb);
					modelT = alu[64];
				end
				opAluCmp: begin
					modelT = alu[64];
				end
				opMovRm: begin
					memModel[idx] = op.valRm;
					holdOps++;
				end
				opMovMr: begin
					wb.value = memModel[idx];
					expQ.push_back(wb);
					holdOps++;
				end
				opMul3: begin
					holdOps++;
					case (mode)
						mulSignedLow: begin
							wb.value = {{32{prod[31]}}, prod[31:0]};
							expQ.push_back(wb);
						end
						mulUnsignedLow: begin
							wb.value = {32'b0, prod[31:0]};
							expQ.push_back(wb);
						end
						mulSignedWide: begin
							modelDlr = {32'b0, prod[31:0]};
							modelDhr = {{32{prod[63]}}, prod[63:32]};
						end
						default: begin
							modelDlr = {32'b0, prod[31:0]};
							modelDhr = {32'b0, prod[63:32]};
						end
					endcase
				end
				default: begin
				end
			endcase
		end
	endfunction

	task automatic checkValue(input string name, input word64 got, input word64 expected);
		checks++;
		assert (got === expected) else begin
			errors++;
			$display("ERR t=%0t %s expected %h got %h", $time, name, expected, got);
		end
	endtask

	task automatic checkTrue(input logic ok, input string what);
		checks++;
		assert (ok) else begin
			errors++;
			$display("t=%0t %s", $time, what);
		end
	endtask

	// Holds the op steady until the core can take it
	task automatic issueOp(input microOp op);
		@(negedge clock);
		inOp    = op;
		opValid = 1'b1;
		while (exHold) begin
			@(negedge clock);
		end
		predictOp(op);	// Accepted on the coming edge
	endtask

	task automatic drainPipe();
		int quiet;
		int waited;
		quiet  = 0;
		waited = 0;
		@(negedge clock);
		opValid = 1'b0;
		inOp    = '0;
		while (quiet < 3 && waited < drainLimit) begin
			@(negedge clock);
			waited++;
			quiet = exHold ? 0 : quiet + 1;
		end
		checkTrue(quiet >= 3, "pipeline stayed in hold and did not drain");
		checkTrue(expQ.size() == 0,
			$sformatf("%0d expected write-backs never appeared", expQ.size()));
		expQ.delete();
		checkValue("srT", 64'(srT), 64'(modelT));
		checkValue("dlr", dlr, modelDlr);
		checkValue("dhr", dhr, modelDhr);
		checkTrue(holdRises == holdOps, $sformatf(
			"exHold went high %0d times for %0d memory and multiply ops", holdRises, holdOps));
	endtask

	task automatic startTest();
		testChecks = checks;
		testErrors = errors;
	endtask

	task automatic endTest(input string name);
		tests++;
		$display("test %s: %0d checks, %0d errors", name, checks - testChecks,
			errors - testErrors);
	endtask

	// Write-back checker, outputs settle well before the falling edge
	always @(negedge clock) begin
		wbPort expected;
		if (!rst && gprWb.valid) begin
			checkTrue(expQ.size() != 0, $sformatf("unexpected write-back to r%0d", gprWb.id));
			if (expQ.size() != 0) begin
				expected = expQ.pop_front();
				checkValue("gprWb.id", 64'(gprWb.id), 64'(expected.id));
				checkValue("gprWb.value", gprWb.value, expected.value);
			end
		end
	end

	// One rise per memory or multiply op
	always @(negedge clock) begin
		if (rst) begin
			prevHold = 1'b0;
		end else begin
			if (exHold && !prevHold) begin
				holdRises++;
			end
			prevHold = exHold;
		end
	end

	initial begin
		#(watchdogCycles * clockPeriod);
		$display("watchdog expired after %0d cycles, the run did not finish", watchdogCycles);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		word64       a;
		word64       b;
		word64       base;
		immVal       disp;
		regId        rm;
		logic [1:0]  pred;
		microOp      op;
		rst       = 1'b1;
		opValid   = 1'b0;
		inOp      = '0;
		modelT    = 1'b0;
		modelDlr  = '0;
		modelDhr  = '0;
		holdOps   = 0;
		holdRises = 0;
		prevHold  = 1'b0;
		checks    = 0;
		errors    = 0;
		tests     = 0;
		for (int k = 0; k < memDepthWords; k++) begin
			memModel[k] = '0;	// Memory clears at reset
		end
		void'($urandom(32'h5178_6b43));
		repeat (10) @(negedge clock);
		rst = 1'b0;

		startTest();
		checkValue("exHold", 64'(exHold), 64'd0);
		checkValue("gprWb.valid", 64'(gprWb.valid), 64'd0);
		checkValue("srT", 64'(srT), 64'd0);
		checkValue("dlr", dlr, 64'd0);
		checkValue("dhr", dhr, 64'd0);
		endTest("reset");

		startTest();
		for (int f = 0; f < 7; f++) begin
			for (int r = 0; r < aluReps; r++) begin
				a = randWord();
				b = (r == 0) ? a : randWord();	// Equal pair hits the true compare
				rm = 6'($urandom_range(1, 63));
				issueOp(makeOp(predAlways, opAlu3, aluFuncs[f], rm, a, b, '0, '0));
			end
		end
		drainPipe();
		endTest("alu3 write-back");

		startTest();
		a = randWord();
		issueOp(makeOp(predAlways, opAluCmp, aluCmpEq, 6'd0, a, a, '0, '0));	// T set
		drainPipe();
		checkValue("srT", 64'(srT), 64'd1);
		issueOp(makeOp(predNever, opAlu3, aluAdd, 6'd3, a, a, '0, '0));
		issueOp(makeOp(predIfFalse, opAlu3, aluAdd, 6'd4, a, a, '0, '0));
		issueOp(makeOp(predIfTrue, opAlu3, aluOr, 6'd5, a, randWord(), '0, '0));	// Clears T
		issueOp(makeOp(predAlways, opAluCmp, aluCmpGt, 6'd0, '1, 64'd5, '0, '0));	// -1 > 5
		issueOp(makeOp(predIfTrue, opAlu3, aluXor, 6'd6, a, a, '0, '0));
		issueOp(makeOp(predIfFalse, opMul3, uIxt'(mulSignedLow), 6'd7, randWord(), randWord(),
			'0, '0));
		issueOp(makeOp(predIfTrue, opMovMr, aluAdd, 6'd8, 64'h40, '0, '0, '0));	// Skipped
		issueOp(makeOp(predIfFalse, opMovRm, aluAdd, 6'd0, 64'h40, '0, randWord(), '0));
		issueOp(makeOp(predIfFalse, opMovMr, aluAdd, 6'd9, 64'h40, '0, '0, '0));
		drainPipe();
		checkValue("srT", 64'(srT), 64'd0);
		endTest("compare and predication");

		startTest();
		for (int m = 0; m < 4; m++) begin
			for (int r = 0; r < mulReps; r++) begin
				a = randWord();
				b = randWord();
				if (r == mulReps - 1) begin
					a[31:30] = 2'b11;	// Top product bit set so DHR shows its extension
					b[31:30] = m[0] ? 2'b11 : 2'b01;	// Signed modes get negative times positive
				end
				rm = 6'($urandom_range(1, 63));
				issueOp(makeOp(predAlways, opMul3, uIxt'(m), rm, a, b, '0, '0));
			end
			drainPipe();	// DLR and DHR per mode
		end
		endTest("multiply modes");

		startTest();
		a = randWord();
		b = randWord();
		issueOp(makeOp(predAlways, opMovRm, aluAdd, 6'd0, 64'h100, '0, a, '0));
		issueOp(makeOp(predAlways, opMovMr, aluAdd, 6'd10, 64'h100, '0, '0, '0));
		issueOp(makeOp(predAlways, opMovMr, aluAdd, 6'd11, 64'h600, '0, '0, '0));	// Untouched
		issueOp(makeOp(predAlways, opMovRm, aluAdd, 6'd0, 64'h208, '0, b, immVal'(-8)));
		issueOp(makeOp(predAlways, opMovMr, aluAdd, 6'd12, 64'h1F0, '0, '0, immVal'(16)));
		a = randWord();
		issueOp(makeOp(predAlways, opMovRm, aluAdd, 6'd0, 64'h100, '0, a, '0));	// Overwrite
		issueOp(makeOp(predAlways, opMovMr, aluAdd, 6'd13, 64'h100, '0, '0, '0));
		drainPipe();
		endTest("memory ordering");

		startTest();
		for (int i = 0; i < burstLen; i++) begin
			pred = ($urandom_range(0, 3) == 0) ? 2'($urandom_range(1, 3)) : predAlways;
			a    = randWord();
			b    = ($urandom_range(0, 1) == 0) ? a : randWord();
			base = 64'(8 * $urandom_range(0, 15));	// Small window so loads hit stores
			disp = immVal'(8 * $urandom_range(0, 3));
			rm   = 6'($urandom_range(1, 63));
			case ($urandom_range(0, 4))
				0: op = makeOp(pred, opAlu3, aluFuncs[$urandom_range(0, 6)], rm, a, b, '0, '0);
				1: op = makeOp(pred, opAluCmp, aluFuncs[$urandom_range(5, 6)], rm, a, b, '0, '0);
				2: op = makeOp(pred, opMovRm, aluAdd, rm, base, '0, a, disp);
				3: op = makeOp(pred, opMovMr, aluAdd, rm, base, '0, '0, disp);
				default: op = makeOp(pred, opMul3, uIxt'($urandom_range(0, 3)), rm, a, b, '0, '0);
			endcase
			issueOp(op);
		end
		drainPipe();
		endTest("back-pressure burst");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
exPkg.sv
exAlu.sv
exMultiplier.sv
dataMemory.sv
sprFile.sv
exStage1.sv
exStage2.sv
exCore.sv
exCoreTb.sv

// ==== Makefile ====
# Verilator build and run for the execute core testbench

VERILATOR ?= verilator
TOP       ?= exCoreTb
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, fail unless the run passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJDIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJDIR)
